// File: build.f
source/cache_pkg.sv
source/cache_req_if.sv
source/cache_way_if.sv
source/cache_plru.sv
source/cache_lookup.sv
source/cache_ctrl.sv
source/cache_data_store.sv
source/cache_top.sv
tests/cache_props.sv
tests/cache_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the cache testbench, fail if the log reports a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f build.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// File: source/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
    input  logic             clk,
    input  logic             rst,
    cache_req_if.sink        req,
    cache_way_if.sink        ways,
    input  logic             dfp_resp,
    output logic             accept,
    output logic             tag_we,
    output logic             tag_dirty,
    output cache_pkg::way_t  access_way,
    output logic             touch,
    output logic             fill_we,
    output logic             word_we,
    output logic             ufp_resp,
    output logic             dfp_read,
    output logic             dfp_write,
    output cache_pkg::addr_t dfp_addr
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;
    logic         is_write;

    assign is_write = |req.wmask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        accept     = 1'b0;
        tag_we     = 1'b0;
        tag_dirty  = 1'b0;
        touch      = 1'b0;
        fill_we    = 1'b0;
        word_we    = 1'b0;
        ufp_resp   = 1'b0;
        dfp_read   = 1'b0;
        dfp_write  = 1'b0;
        access_way = ways.hit_way;
        dfp_addr   = {req.tag, req.set_idx, offset_t'(0)};  // request line

        unique case (state)
            IDLE: begin
                accept     = 1'b1;
                state_next = COMPARE;
            end
            COMPARE: begin
                if (!req.req_valid) begin
                    state_next = IDLE;  // nothing was presented
                end else if (ways.hit) begin
                    ufp_resp   = 1'b1;
                    touch      = 1'b1;
                    word_we    = is_write;
                    tag_we     = is_write;
                    tag_dirty  = 1'b1;
                    state_next = IDLE;
                end else begin
                    state_next = ways.victim_dirty ? WRITEBACK : FILL;
                end
            end
            WRITEBACK: begin
                access_way = ways.victim_way;
                dfp_write  = 1'b1;
                dfp_addr   = {ways.victim_tag, req.set_idx, offset_t'(0)};
                if (dfp_resp) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                access_way = ways.victim_way;
                dfp_read   = 1'b1;
                if (dfp_resp) begin
                    fill_we    = 1'b1;
                    tag_we     = 1'b1;
                    tag_dirty  = is_write;  // write data is merged into the fill
                    state_next = RESPOND;
                end
            end
            RESPOND: begin
                ufp_resp   = 1'b1;      // line now hits in the filled way
                touch      = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// File: source/cache_data_store.sv
`timescale 1ns/1ns

module cache_data_store (
    input  logic             clk,
    cache_req_if.sink        req,
    input  cache_pkg::way_t  access_way,
    input  logic             fill_we,
    input  logic             word_we,
    input  cache_pkg::line_t dfp_rdata,
    input  cache_pkg::way_t  victim_way,
    output cache_pkg::line_t dfp_wdata,
    output cache_pkg::word_t ufp_rdata
);
    import cache_pkg::*;

    localparam int WORD_IDX_BITS = OFFSET_BITS - $clog2(MASK_BITS);

    line_t                    data_arr [NUM_WAYS][NUM_SETS];
    line_t                    cur_line;
    line_t                    new_line;
    logic [WORD_IDX_BITS-1:0] word_idx;

    assign word_idx = req.offset[OFFSET_BITS-1:$clog2(MASK_BITS)];
    assign cur_line = data_arr[access_way][req.set_idx];

    // fill starts from memory data, a word write from the stored line
    always_comb begin
        new_line = fill_we ? dfp_rdata : cur_line;
        for (int b = 0; b < MASK_BITS; b++) begin
            if (req.wmask[b]) begin
                new_line[(word_idx * MASK_BITS + b) * 8 +: 8] = req.wdata[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we || word_we) begin
            data_arr[access_way][req.set_idx] <= new_line;
        end
    end

    assign dfp_wdata = data_arr[victim_way][req.set_idx];   // write-back source
    assign ufp_rdata = cur_line[word_idx * WORD_BITS +: WORD_BITS];

endmodule

// File: source/cache_lookup.sv
`timescale 1ns/1ns

module cache_lookup (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t ufp_addr,
    input  cache_pkg::mask_t ufp_rmask,
    input  cache_pkg::mask_t ufp_wmask,
    input  cache_pkg::word_t ufp_wdata,
    input  logic             accept,
    input  logic             tag_we,
    input  logic             tag_dirty,
    input  cache_pkg::way_t  access_way,
    input  logic             touch,
    cache_req_if.source      req,
    cache_way_if.source      ways
);
    import cache_pkg::*;

    tag_t tag_arr   [NUM_WAYS][NUM_SETS];
    logic valid_arr [NUM_WAYS][NUM_SETS];
    logic dirty_arr [NUM_WAYS][NUM_SETS];

    // request register, masks are the control part
    always_ff @(posedge clk) begin
        if (rst) begin
            req.rmask <= '0;
            req.wmask <= '0;
        end else if (accept) begin
            req.rmask <= ufp_rmask;
            req.wmask <= ufp_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.tag     <= ufp_addr[OFFSET_BITS+SET_BITS +: TAG_BITS];
            req.set_idx <= ufp_addr[OFFSET_BITS +: SET_BITS];
            req.offset  <= ufp_addr[OFFSET_BITS-1:0];
            req.wdata   <= ufp_wdata;
        end
    end

    assign req.req_valid = (|req.rmask) | (|req.wmask);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    valid_arr[w][s] <= 1'b0;
                end
            end
        end else if (tag_we) begin
            valid_arr[access_way][req.set_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_arr[access_way][req.set_idx]   <= req.tag;
            dirty_arr[access_way][req.set_idx] <= tag_dirty;
        end
    end

    // compare against all ways, at most one matches
    always_comb begin
        ways.hit     = 1'b0;
        ways.hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_arr[w][req.set_idx] && tag_arr[w][req.set_idx] == req.tag) begin
                ways.hit     = 1'b1;
                ways.hit_way = way_t'(w);
            end
        end
    end

    cache_plru i_cache_plru (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (req.set_idx),
        .touch      (touch),
        .access_way (access_way),
        .victim_way (ways.victim_way)
    );

    assign ways.victim_tag   = tag_arr[ways.victim_way][req.set_idx];
    assign ways.victim_dirty = valid_arr[ways.victim_way][req.set_idx]
                             & dirty_arr[ways.victim_way][req.set_idx];

endmodule

// File: source/cache_pkg.sv
package cache_pkg;

    // geometry of the cache
    localparam int NUM_WAYS    = 4;
    localparam int NUM_SETS    = 16;
    localparam int TAG_BITS    = 23;
    localparam int SET_BITS    = 4;
    localparam int OFFSET_BITS = 5;
    localparam int LINE_BITS   = 256;
    localparam int WORD_BITS   = 32;
    localparam int MASK_BITS   = 4;

    // address split is tag | set | offset
    typedef logic [TAG_BITS+SET_BITS+OFFSET_BITS-1:0] addr_t;
    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [SET_BITS-1:0]        set_idx_t;
    typedef logic [OFFSET_BITS-1:0]     offset_t;
    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [MASK_BITS-1:0]       mask_t;     // one bit per byte lane
    typedef logic [LINE_BITS-1:0]       line_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
    typedef logic [NUM_WAYS-2:0]        plru_t;     // tree bits, root is bit 0

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITEBACK,  // victim line out to memory
        FILL,       // new line in from memory
        RESPOND
    } cache_state_t;

endpackage

// File: source/cache_plru.sv
`timescale 1ns/1ns

module cache_plru (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t set_idx,
    input  logic                touch,
    input  cache_pkg::way_t     access_way,
    output cache_pkg::way_t     victim_way
);
    import cache_pkg::*;

    plru_t plru_arr [NUM_SETS];
    plru_t bits;

    assign bits = plru_arr[set_idx];

    // follow the branches away from the recent side
    always_comb begin
        if (bits[0]) begin
            victim_way = bits[1] ? way_t'(0) : way_t'(1);
        end else begin
            victim_way = bits[2] ? way_t'(2) : way_t'(3);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_arr[s] <= '0;
            end
        end else if (touch) begin
            plru_arr[set_idx][0] <= access_way[1];  // points at the side just used
            if (access_way[1]) begin
                plru_arr[set_idx][2] <= access_way[0];
            end else begin
                plru_arr[set_idx][1] <= access_way[0];
            end
        end
    end

endmodule

// File: source/cache_req_if.sv
`timescale 1ns/1ns

interface cache_req_if;
    import cache_pkg::*;

    logic     req_valid;    // registered request has a nonzero mask
    tag_t     tag;
    set_idx_t set_idx;
    offset_t  offset;
    mask_t    rmask;
    mask_t    wmask;
    word_t    wdata;

    modport source (
        output req_valid, tag, set_idx, offset, rmask, wmask, wdata
    );

    modport sink (
        input req_valid, tag, set_idx, offset, rmask, wmask, wdata
    );

endinterface

// File: source/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::addr_t  ufp_addr,
    input  cache_pkg::mask_t  ufp_rmask,
    input  cache_pkg::mask_t  ufp_wmask,
    input  cache_pkg::word_t  ufp_wdata,
    output cache_pkg::word_t  ufp_rdata,
    output logic              ufp_resp,
    output cache_pkg::addr_t  dfp_addr,
    output logic              dfp_read,
    output logic              dfp_write,
    output cache_pkg::line_t  dfp_wdata,
    input  cache_pkg::line_t  dfp_rdata,
    input  logic              dfp_resp
);
    import cache_pkg::*;

    logic accept;
    logic tag_we;
    logic tag_dirty;
    logic touch;
    logic fill_we;
    logic word_we;
    way_t access_way;

    cache_req_if req_bus ();
    cache_way_if way_bus ();

    cache_lookup i_cache_lookup (
        .clk        (clk),
        .rst        (rst),
        .ufp_addr   (ufp_addr),
        .ufp_rmask  (ufp_rmask),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .accept     (accept),
        .tag_we     (tag_we),
        .tag_dirty  (tag_dirty),
        .access_way (access_way),
        .touch      (touch),
        .req        (req_bus.source),
        .ways       (way_bus.source)
    );

    cache_ctrl i_cache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req_bus.sink),
        .ways       (way_bus.sink),
        .dfp_resp   (dfp_resp),
        .accept     (accept),
        .tag_we     (tag_we),
        .tag_dirty  (tag_dirty),
        .access_way (access_way),
        .touch      (touch),
        .fill_we    (fill_we),
        .word_we    (word_we),
        .ufp_resp   (ufp_resp),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write),
        .dfp_addr   (dfp_addr)
    );

    cache_data_store i_cache_data_store (
        .clk        (clk),
        .req        (req_bus.sink),
        .access_way (access_way),
        .fill_we    (fill_we),
        .word_we    (word_we),
        .dfp_rdata  (dfp_rdata),
        .victim_way (way_bus.victim_way),
        .dfp_wdata  (dfp_wdata),
        .ufp_rdata  (ufp_rdata)
    );

endmodule

// File: source/cache_way_if.sv
`timescale 1ns/1ns

interface cache_way_if;
    import cache_pkg::*;

    logic hit;
    way_t hit_way;
    way_t victim_way;       // plru choice for the request set
    logic victim_dirty;     // valid and dirty
    tag_t victim_tag;

    modport source (
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport sink (
        input hit, hit_way, victim_way, victim_dirty, victim_tag
    );

endinterface

// File: tests/cache_props.sv
`timescale 1ns/1ns

module cache_props (
    input logic clk,
    input logic rst,
    input logic ufp_resp,
    input logic dfp_read,
    input logic dfp_write,
    input logic dfp_resp
);

    resp_single: assert property (@(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp)
        else $error("ufp_resp high for two cycles in a row");

    dfp_exclusive: assert property (@(posedge clk) disable iff (rst) !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high together");

    // a memory request stays up until it is answered
    read_hold: assert property (@(posedge clk) disable iff (rst)
        (dfp_read && !dfp_resp) |=> dfp_read)
        else $error("dfp_read dropped before dfp_resp");

    write_hold: assert property (@(posedge clk) disable iff (rst)
        (dfp_write && !dfp_resp) |=> dfp_write)
        else $error("dfp_write dropped before dfp_resp");

endmodule

bind cache_top cache_props i_cache_props (
    .clk       (clk),
    .rst       (rst),
    .ufp_resp  (ufp_resp),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .dfp_resp  (dfp_resp)
);

// File: tests/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;
    import cache_pkg::*;

    localparam int MAX_REQS    = 64;
    localparam int MISS_CYCLES = 24;    // write-back plus fill at the longest memory delay

    logic  clk = 1'b0;
    logic  rst;
    addr_t ufp_addr;
    mask_t ufp_rmask;
    mask_t ufp_wmask;
    word_t ufp_wdata;
    word_t ufp_rdata;
    logic  ufp_resp;
    addr_t dfp_addr;
    logic  dfp_read;
    logic  dfp_write;
    line_t dfp_wdata;
    line_t dfp_rdata;
    logic  dfp_resp;

    logic [15:0] lfsr = 16'd73;
    int          errors = 0;
    int          checks = 0;
    int          mem_reads = 0;
    int          mem_writes = 0;
    logic [7:0]  ref_bytes [addr_t];    // bytes written by the cpu
    line_t       mem_lines [addr_t];    // lines written back
    logic        mem_ops [$];           // 1 marks a write-back and 0 a fill
    addr_t       mem_addrs [$];

    cache_top i_cache_top (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    always #2 clk = ~clk;

    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    function automatic addr_t addr_of(tag_t t, set_idx_t s, int w);
        return {t, s, 3'(w), 2'b00};
    endfunction

    // every bit of the address reaches the word
    function automatic word_t pattern_word(addr_t a);
        return a ^ {a[12:0], a[31:13]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [7:0] ref_byte(addr_t a);
        word_t w;
        w = pattern_word({a[31:2], 2'b00});
        if (ref_bytes.exists(a)) begin
            return ref_bytes[a];
        end
        return w[a[1:0] * 8 +: 8];
    endfunction

    function automatic word_t ref_word(addr_t a);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[b * 8 +: 8] = ref_byte({a[31:2], 2'b00} + addr_t'(b));
        end
        return w;
    endfunction

    function automatic line_t ref_line(addr_t base);
        line_t l;
        for (int i = 0; i < 32; i++) begin
            l[i * 8 +: 8] = ref_byte(base + addr_t'(i));
        end
        return l;
    endfunction

    function automatic line_t memory_line(addr_t base);
        line_t l;
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end
        for (int i = 0; i < 8; i++) begin
            l[i * 32 +: 32] = pattern_word(base + addr_t'(i * 4));
        end
        return l;
    endfunction

    function automatic way_t plru_victim(plru_t b);
        if (b[0]) begin
            return b[1] ? way_t'(0) : way_t'(1);
        end
        return b[2] ? way_t'(2) : way_t'(3);
    endfunction

    function automatic plru_t plru_touch(plru_t b, way_t w);
        plru_t n;
        n = b;
        n[0] = (w == 2) || (w == 3);
        if (w < 2) begin
            n[1] = (w == 1);
        end else begin
            n[2] = (w == 3);
        end
        return n;
    endfunction

    // memory model serving one transfer at a time
    initial begin
        addr_t a;
        logic  wr;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && (dfp_read || dfp_write)) begin
                a  = dfp_addr;
                wr = dfp_write;
                mem_ops.push_back(wr);
                mem_addrs.push_back(a);
                if (wr) begin
                    mem_writes++;
                    checks++;
                    if (dfp_wdata !== ref_line(a)) begin
                        errors++;
                        $display("FAILED %0t: write-back of line %h has wrong data", $time, a);
                    end
                    mem_lines[a] = dfp_wdata;
                end else begin
                    mem_reads++;
                end
                repeat (1 + rand_bits(2)) @(posedge clk);
                #1;
                dfp_resp  = 1'b1;
                dfp_rdata = memory_line(a);
                @(posedge clk);
                #1;
                dfp_resp  = 1'b0;
            end
        end
    end

    // starts 1 ns after an edge and returns 1 ns after the edge that ends the response
    task automatic cpu_access(input addr_t a, input mask_t rm, input mask_t wm,
                              input word_t wd, output word_t rd);
        ufp_addr  = a;
        ufp_rmask = rm;
        ufp_wmask = wm;
        ufp_wdata = wd;
        do begin
            @(negedge clk);
        end while (!ufp_resp);
        rd = ufp_rdata;
        for (int b = 0; b < 4; b++) begin
            if (wm[b]) begin
                ref_bytes[{a[31:2], 2'b00} + addr_t'(b)] = wd[b * 8 +: 8];
            end
        end
        @(posedge clk);
        #1;
        ufp_rmask = '0;
        ufp_wmask = '0;
    endtask

    task automatic read_check(input addr_t a);
        word_t rd;
        cpu_access(a, 4'hf, 4'h0, '0, rd);
        checks++;
        if (rd !== ref_word(a)) begin
            errors++;
            $display("FAILED %0t: read %h got %h expected %h", $time, a, rd, ref_word(a));
        end
    endtask

    task automatic write_word(input addr_t a, input mask_t m, input word_t wd);
        word_t rd;
        cpu_access(a, 4'h0, m, wd, rd);
    endtask

    task automatic expect_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %0t: %s is %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic reset_and_first_miss();
        int r0;
        @(negedge clk);
        checks++;
        if (ufp_resp || dfp_read || dfp_write) begin
            errors++;
            $display("FAILED %0t: outputs not idle after reset", $time);
        end
        @(posedge clk);
        #1;
        r0 = mem_reads;
        read_check(addr_of(23'h40, 4'd0, 0));
        expect_count(mem_reads - r0, 1, "fills on first read");
    endtask

    task automatic read_miss_then_hit();
        int r0;
        read_check(addr_of(23'h51, 4'd1, 3));   // miss
        r0 = mem_reads + mem_writes;
        read_check(addr_of(23'h51, 4'd1, 3));
        expect_count(mem_reads + mem_writes - r0, 0, "memory requests on read hit");
    endtask

    task automatic write_hit_merge();
        int r0;
        r0 = mem_reads + mem_writes;
        write_word(addr_of(23'h51, 4'd1, 5), 4'b0110, 32'hdead_beef);
        read_check(addr_of(23'h51, 4'd1, 5));
        expect_count(mem_reads + mem_writes - r0, 0, "memory requests on write hit");
    endtask

    task automatic write_miss_fill();
        int r0;
        r0 = mem_reads;
        write_word(addr_of(23'h62, 4'd2, 6), 4'b1001, 32'ha1b2_c3d4);
        expect_count(mem_reads - r0, 1, "fills on write miss");
        read_check(addr_of(23'h62, 4'd2, 6));
        read_check(addr_of(23'h62, 4'd2, 0));
    endtask

    // five tags in set 5 where the last one evicts a dirty line
    task automatic evict_in_one_set();
        plru_t bits;
        tag_t  way_tag [NUM_WAYS];
        way_t  v;
        tag_t  t;
        bits = '0;
        for (int i = 0; i < 5; i++) begin
            v = plru_victim(bits);
            t = tag_t'(23'h70 + i);
            mem_ops.delete();
            mem_addrs.delete();
            write_word(addr_of(t, 4'd5, i), 4'hf, 32'h5000_0000 + i);
            checks++;
            if (i < 4 && !(mem_ops.size() == 1 && !mem_ops[0])) begin
                errors++;
                $display("FAILED %0t: miss %0d expected one fill only", $time, i);
            end
            if (i == 4 && !(mem_ops.size() == 2 && mem_ops[0] && !mem_ops[1]
                    && mem_addrs[0] == addr_of(way_tag[v], 4'd5, 0)
                    && mem_addrs[1] == addr_of(t, 4'd5, 0))) begin
                errors++;
                $display("FAILED %0t: eviction of way %0d not write-back then fill", $time, v);
            end
            way_tag[v] = t;
            bits = plru_touch(bits, v);
        end
        for (int i = 0; i < 5; i++) begin
            read_check(addr_of(tag_t'(23'h70 + i), 4'd5, i));
        end
    endtask

    task automatic random_mix();
        addr_t a;
        mask_t m;
        for (int i = 0; i < 40; i++) begin
            a = addr_of(tag_t'(23'h100 + rand_bits(3)), set_idx_t'(8 + rand_bits(2) % 3),
                        rand_bits(3));
            m = mask_t'(rand_bits(4));
            if (rand_bits(1) == 1) begin
                write_word(a, (m == 0) ? 4'hf : m, word_t'(rand_bits(32)));
            end else begin
                read_check(a);
            end
        end
    endtask

    initial begin
        #((MAX_REQS * MISS_CYCLES + 10) * 4);
        $display("watchdog timeout, the DUT stopped responding");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_and_first_miss();
        read_miss_then_hit();
        write_hit_merge();
        write_miss_fill();
        evict_in_one_set();
        random_mix();
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, fills %0d, write-backs %0d",
                 checks, errors, mem_reads, mem_writes);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
